//--- common/rob_config.svh
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// number of entries, kept a power of two
`define ROB_SIZE 16

// base-2 log of ROB_SIZE
`define ROB_IDX_W 4

// program counter width
`define PC_W 32

// logical register number
`define LREG_W 5

// physical register number
`define PREG_W 6

`endif

//--- common/rob_pkg.sv
`default_nettype none
`include "rob_config.svh"

package rob_pkg;

    // recovery states
    localparam logic [1:0] ROB_STATE_IDLE      = 2'd0;
    localparam logic [1:0] ROB_STATE_OVERWRITE = 2'd1;
    localparam logic [1:0] ROB_STATE_WALKING   = 2'd2;

    // pointers carry a wrap flag above the index
    function automatic logic [`ROB_IDX_W:0] rob_free_slots(
        input logic [`ROB_IDX_W:0] enq_ptr,
        input logic [`ROB_IDX_W:0] deq_ptr
    );
        logic [`ROB_IDX_W:0] used;
        logic [`ROB_IDX_W:0] size;
        used = enq_ptr - deq_ptr;
        size = (`ROB_IDX_W + 1)'(`ROB_SIZE);
        return size - used;
    endfunction

    // strictly between the flush entry and the enqueue slot, circularly
    function automatic logic rob_is_flushed(
        input logic [`ROB_IDX_W-1:0] idx,
        input logic [`ROB_IDX_W-1:0] flush_idx,
        input logic [`ROB_IDX_W-1:0] enq_idx
    );
        logic [`ROB_IDX_W-1:0] idx_dist;
        logic [`ROB_IDX_W-1:0] enq_dist;
        idx_dist = idx - flush_idx;
        enq_dist = enq_idx - flush_idx;
        // zero distance to the enqueue slot only happens on a full buffer
        return (idx_dist != '0) && ((enq_dist == '0) || (idx_dist < enq_dist));
    endfunction

endpackage

`default_nettype wire

//--- rob/rob_entry_array.sv
`timescale 1ns/10ps
`default_nettype none
`include "rob_config.svh"

module rob_entry_array (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   enq0_we,
    input  wire                   enq1_we,
    input  wire [`ROB_IDX_W-1:0]  enq0_idx,
    input  wire [`ROB_IDX_W-1:0]  enq1_idx,
    input  wire [`PC_W-1:0]       enq0_pc,
    input  wire [`LREG_W-1:0]     enq0_lrd,
    input  wire [`PREG_W-1:0]     enq0_prd,
    input  wire [`PREG_W-1:0]     enq0_old_prd,
    input  wire                   enq0_need_to_wb,
    input  wire [`PC_W-1:0]       enq1_pc,
    input  wire [`LREG_W-1:0]     enq1_lrd,
    input  wire [`PREG_W-1:0]     enq1_prd,
    input  wire [`PREG_W-1:0]     enq1_old_prd,
    input  wire                   enq1_need_to_wb,
    input  wire                   wb0_valid,
    input  wire [`ROB_IDX_W-1:0]  wb0_robidx,
    input  wire                   wb1_valid,
    input  wire [`ROB_IDX_W-1:0]  wb1_robidx,
    input  wire                   wb1_mmio,
    input  wire                   wb2_valid,
    input  wire [`ROB_IDX_W-1:0]  wb2_robidx,
    input  wire                   commit_fire,
    input  wire [`ROB_IDX_W-1:0]  head_idx,
    input  wire [1:0]             state,
    input  wire [`ROB_IDX_W-1:0]  flush_idx,
    input  wire [`ROB_IDX_W-1:0]  enq_idx,
    output logic [`ROB_SIZE-1:0]  entry_valid,
    output logic [`ROB_SIZE-1:0]  entry_done,
    output logic [`ROB_SIZE-1:0]  entry_need_wb,
    output logic [`PC_W-1:0]      head_pc,
    output logic [`LREG_W-1:0]    head_lrd,
    output logic [`PREG_W-1:0]    head_prd,
    output logic [`PREG_W-1:0]    head_old_prd,
    output logic                  head_skip,
    input  wire [`ROB_IDX_W-1:0]  walk0_idx,
    input  wire [`ROB_IDX_W-1:0]  walk1_idx,
    output logic [`LREG_W-1:0]    walk0_lrd,
    output logic [`PREG_W-1:0]    walk0_prd,
    output logic [`LREG_W-1:0]    walk1_lrd,
    output logic [`PREG_W-1:0]    walk1_prd
);
    import rob_pkg::*;

    localparam int IDX_W = `ROB_IDX_W;

    logic [`PC_W-1:0]     pc_q      [`ROB_SIZE];
    logic [`LREG_W-1:0]   lrd_q     [`ROB_SIZE];
    logic [`PREG_W-1:0]   prd_q     [`ROB_SIZE];
    logic [`PREG_W-1:0]   old_prd_q [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] skip_q;
    logic [`ROB_SIZE-1:0] enq0_hit;
    logic [`ROB_SIZE-1:0] enq1_hit;
    logic [`ROB_SIZE-1:0] wb_hit;
    logic [`ROB_SIZE-1:0] skip_hit;
    logic [`ROB_SIZE-1:0] flush_hit;
    logic [`ROB_SIZE-1:0] commit_hit;

    // one-hot decode of every port onto the entries
    always_comb begin
        for (int i = 0; i < `ROB_SIZE; i++) begin
            enq0_hit[i]   = enq0_we && (enq0_idx == IDX_W'(i));
            enq1_hit[i]   = enq1_we && (enq1_idx == IDX_W'(i));
            wb_hit[i]     = (wb0_valid && (wb0_robidx == IDX_W'(i)))
                         || (wb1_valid && (wb1_robidx == IDX_W'(i)))
                         || (wb2_valid && (wb2_robidx == IDX_W'(i)));
            // only the load/store port reports mmio
            skip_hit[i]   = wb1_valid && wb1_mmio && (wb1_robidx == IDX_W'(i));
            flush_hit[i]  = (state == ROB_STATE_OVERWRITE)
                         && rob_is_flushed(IDX_W'(i), flush_idx, enq_idx);
            commit_hit[i] = commit_fire && (head_idx == IDX_W'(i));
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            entry_valid   <= '0;
            entry_done    <= '0;
            entry_need_wb <= '0;
            skip_q        <= '0;
        end else begin
            for (int i = 0; i < `ROB_SIZE; i++) begin
                if (flush_hit[i]) begin
                    entry_valid[i] <= 1'b0;
                end else if (enq0_hit[i] || enq1_hit[i]) begin
                    entry_valid[i]   <= 1'b1;
                    entry_done[i]    <= 1'b0;
                    skip_q[i]        <= 1'b0;
                    entry_need_wb[i] <= enq0_hit[i] ? enq0_need_to_wb : enq1_need_to_wb;
                end else begin
                    if (commit_hit[i]) begin
                        entry_valid[i] <= 1'b0;
                    end
                    if (wb_hit[i]) begin
                        entry_done[i] <= 1'b1;
                    end
                    if (skip_hit[i]) begin
                        skip_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // payload fields
    always_ff @(posedge clock) begin
        if (enq0_we) begin
            pc_q[enq0_idx]      <= enq0_pc;
            lrd_q[enq0_idx]     <= enq0_lrd;
            prd_q[enq0_idx]     <= enq0_prd;
            old_prd_q[enq0_idx] <= enq0_old_prd;
        end
        if (enq1_we) begin
            pc_q[enq1_idx]      <= enq1_pc;
            lrd_q[enq1_idx]     <= enq1_lrd;
            prd_q[enq1_idx]     <= enq1_prd;
            old_prd_q[enq1_idx] <= enq1_old_prd;
        end
    end

    assign head_pc      = pc_q[head_idx];
    assign head_lrd     = lrd_q[head_idx];
    assign head_prd     = prd_q[head_idx];
    assign head_old_prd = old_prd_q[head_idx];
    assign head_skip    = skip_q[head_idx];

    // read ports for the rename table rebuild
    assign walk0_lrd = lrd_q[walk0_idx];
    assign walk0_prd = prd_q[walk0_idx];
    assign walk1_lrd = lrd_q[walk1_idx];
    assign walk1_prd = prd_q[walk1_idx];

endmodule

`default_nettype wire

//--- rob/rob_pointers.sv
`timescale 1ns/10ps
`default_nettype none
`include "rob_config.svh"

module rob_pointers (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   enq0_valid,
    input  wire                   enq1_valid,
    input  wire [1:0]             state,
    input  wire [`ROB_IDX_W:0]    flush_ptr,
    input  wire [`ROB_SIZE-1:0]   entry_valid,
    input  wire [`ROB_SIZE-1:0]   entry_done,
    input  wire                   flush_valid,
    input  wire                   commit_ready,
    output logic                  enq_ready,
    output logic                  enq0_we,
    output logic                  enq1_we,
    output logic [`ROB_IDX_W-1:0] enq0_idx,
    output logic [`ROB_IDX_W-1:0] enq1_idx,
    output logic                  enq_robidx_flag,
    output logic [`ROB_IDX_W-1:0] enq_robidx,
    output logic [`ROB_IDX_W-1:0] head_idx,
    output logic                  commit_valid,
    output logic                  commit_fire
);
    import rob_pkg::*;

    localparam int IDX_W = `ROB_IDX_W;
    localparam int PTR_W = `ROB_IDX_W + 1;

    // wrap flag in the top bit, index below
    logic [PTR_W-1:0] enq_ptr;
    logic [PTR_W-1:0] deq_ptr;
    logic [PTR_W-1:0] free_slots;
    logic [1:0]       enq_num;
    logic             is_idle;

    assign is_idle    = (state == ROB_STATE_IDLE);
    assign free_slots = rob_free_slots(enq_ptr, deq_ptr);

    // room for a full pair, and no recovery in progress
    assign enq_ready = is_idle && (free_slots >= PTR_W'(2));

    assign enq0_we  = enq0_valid && enq_ready;
    assign enq1_we  = enq1_valid && enq_ready;
    assign enq_num  = {1'b0, enq0_we} + {1'b0, enq1_we};
    assign enq0_idx = enq_ptr[IDX_W-1:0];
    assign enq1_idx = enq_ptr[IDX_W-1:0] + IDX_W'(1);

    assign enq_robidx_flag = enq_ptr[IDX_W];
    assign enq_robidx      = enq_ptr[IDX_W-1:0];

    assign head_idx = deq_ptr[IDX_W-1:0];

    // a flush request in the same cycle blocks retirement of the head
    assign commit_valid = entry_valid[head_idx] && entry_done[head_idx]
                       && is_idle && !flush_valid;
    assign commit_fire  = commit_valid && commit_ready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            enq_ptr <= '0;
            deq_ptr <= '0;
        end else begin
            if (state == ROB_STATE_OVERWRITE) begin
                // younger entries are gone, restart right after the flush entry
                enq_ptr <= flush_ptr + PTR_W'(1);
            end else begin
                enq_ptr <= enq_ptr + PTR_W'(enq_num);
            end
            if (commit_fire) begin
                deq_ptr <= deq_ptr + PTR_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- rob/rob_recovery.sv
`timescale 1ns/10ps
`default_nettype none
`include "rob_config.svh"

module rob_recovery (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   flush_valid,
    input  wire                   flush_robidx_flag,
    input  wire [`ROB_IDX_W-1:0]  flush_robidx,
    input  wire [`ROB_IDX_W-1:0]  head_idx,
    input  wire [`ROB_SIZE-1:0]   entry_valid,
    input  wire [`ROB_SIZE-1:0]   entry_need_wb,
    input  wire [`LREG_W-1:0]     walk0_lrd,
    input  wire [`PREG_W-1:0]     walk0_prd,
    input  wire [`LREG_W-1:0]     walk1_lrd,
    input  wire [`PREG_W-1:0]     walk1_prd,
    output logic [1:0]            state,
    output logic [`ROB_IDX_W:0]   flush_ptr,
    output logic [`ROB_IDX_W-1:0] walk0_idx,
    output logic [`ROB_IDX_W-1:0] walk1_idx,
    output logic                  walk0_valid,
    output logic                  walk1_valid,
    output logic [`LREG_W-1:0]    walk0_lrd_out,
    output logic [`PREG_W-1:0]    walk0_prd_out,
    output logic [`LREG_W-1:0]    walk1_lrd_out,
    output logic [`PREG_W-1:0]    walk1_prd_out
);
    import rob_pkg::*;

    localparam int IDX_W = `ROB_IDX_W;

    logic [1:0]       state_next;
    logic [IDX_W-1:0] walk_idx;
    logic             is_walking;
    logic             walk_last;

    assign is_walking = (state == ROB_STATE_WALKING);

    assign walk0_idx = walk_idx;
    assign walk1_idx = walk_idx + IDX_W'(1);

    // second lane hits a hole, or the pair reaches the slot just before the head
    assign walk_last = !entry_valid[walk1_idx] || ((walk1_idx + IDX_W'(1)) == head_idx);

    always_comb begin
        state_next = state;
        case (state)
            ROB_STATE_IDLE: begin
                if (flush_valid) begin
                    state_next = ROB_STATE_OVERWRITE;
                end
            end
            // single cycle, flushed entries cleared here
            ROB_STATE_OVERWRITE: begin
                state_next = ROB_STATE_WALKING;
            end
            ROB_STATE_WALKING: begin
                if (walk_last) begin
                    state_next = ROB_STATE_IDLE;
                end
            end
            default: begin
                state_next = ROB_STATE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= ROB_STATE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // flush requests outside idle are not taken
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            flush_ptr <= '0;
        end else if (flush_valid && (state == ROB_STATE_IDLE)) begin
            flush_ptr <= {flush_robidx_flag, flush_robidx};
        end
    end

    // walk starts at the oldest surviving entry
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            walk_idx <= '0;
        end else if (state == ROB_STATE_OVERWRITE) begin
            walk_idx <= head_idx;
        end else if (is_walking) begin
            walk_idx <= walk_idx + IDX_W'(2);
        end
    end

    // only entries that write a register touch the rename table
    assign walk0_valid = is_walking && entry_valid[walk0_idx] && entry_need_wb[walk0_idx];
    assign walk1_valid = is_walking && entry_valid[walk1_idx] && entry_need_wb[walk1_idx];

    assign walk0_lrd_out = walk0_lrd;
    assign walk0_prd_out = walk0_prd;
    assign walk1_lrd_out = walk1_lrd;
    assign walk1_prd_out = walk1_prd;

endmodule

`default_nettype wire

//--- verilog/rob_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "rob_config.svh"

module rob_top (
    input  wire                   clock,
    input  wire                   reset_n,
    input  wire                   enq0_valid,
    input  wire [`PC_W-1:0]       enq0_pc,
    input  wire [`LREG_W-1:0]     enq0_lrd,
    input  wire [`PREG_W-1:0]     enq0_prd,
    input  wire [`PREG_W-1:0]     enq0_old_prd,
    input  wire                   enq0_need_to_wb,
    input  wire                   enq1_valid,
    input  wire [`PC_W-1:0]       enq1_pc,
    input  wire [`LREG_W-1:0]     enq1_lrd,
    input  wire [`PREG_W-1:0]     enq1_prd,
    input  wire [`PREG_W-1:0]     enq1_old_prd,
    input  wire                   enq1_need_to_wb,
    output logic                  enq_ready,
    output logic                  enq_robidx_flag,
    output logic [`ROB_IDX_W-1:0] enq_robidx,
    input  wire                   wb0_valid,
    input  wire [`ROB_IDX_W-1:0]  wb0_robidx,
    input  wire                   wb1_valid,
    input  wire [`ROB_IDX_W-1:0]  wb1_robidx,
    input  wire                   wb1_mmio,
    input  wire                   wb2_valid,
    input  wire [`ROB_IDX_W-1:0]  wb2_robidx,
    output logic                  commit_valid,
    output logic [`PC_W-1:0]      commit_pc,
    output logic [`LREG_W-1:0]    commit_lrd,
    output logic [`PREG_W-1:0]    commit_prd,
    output logic [`PREG_W-1:0]    commit_old_prd,
    output logic                  commit_skip,
    input  wire                   commit_ready,
    input  wire                   flush_valid,
    input  wire                   flush_robidx_flag,
    input  wire [`ROB_IDX_W-1:0]  flush_robidx,
    output logic                  walk0_valid,
    output logic [`LREG_W-1:0]    walk0_lrd,
    output logic [`PREG_W-1:0]    walk0_prd,
    output logic                  walk1_valid,
    output logic [`LREG_W-1:0]    walk1_lrd,
    output logic [`PREG_W-1:0]    walk1_prd
);

    logic                  enq0_we;
    logic                  enq1_we;
    logic [`ROB_IDX_W-1:0] enq0_idx;
    logic [`ROB_IDX_W-1:0] enq1_idx;
    logic [`ROB_IDX_W-1:0] head_idx;
    logic                  commit_fire;
    logic [1:0]            state;
    logic [`ROB_IDX_W:0]   flush_ptr;
    logic [`ROB_SIZE-1:0]  entry_valid;
    logic [`ROB_SIZE-1:0]  entry_done;
    logic [`ROB_SIZE-1:0]  entry_need_wb;
    logic [`ROB_IDX_W-1:0] walk0_idx;
    logic [`ROB_IDX_W-1:0] walk1_idx;
    // raw walk reads from the array
    logic [`LREG_W-1:0]    arr_walk0_lrd;
    logic [`PREG_W-1:0]    arr_walk0_prd;
    logic [`LREG_W-1:0]    arr_walk1_lrd;
    logic [`PREG_W-1:0]    arr_walk1_prd;

    rob_entry_array entry_array_i (
        .flush_idx    (flush_ptr[`ROB_IDX_W-1:0]),
        .enq_idx      (enq_robidx),
        .head_pc      (commit_pc),
        .head_lrd     (commit_lrd),
        .head_prd     (commit_prd),
        .head_old_prd (commit_old_prd),
        .head_skip    (commit_skip),
        .walk0_lrd    (arr_walk0_lrd),
        .walk0_prd    (arr_walk0_prd),
        .walk1_lrd    (arr_walk1_lrd),
        .walk1_prd    (arr_walk1_prd),
        .*
    );

    rob_pointers pointers_i (
        .*
    );

    rob_recovery recovery_i (
        .walk0_lrd     (arr_walk0_lrd),
        .walk0_prd     (arr_walk0_prd),
        .walk1_lrd     (arr_walk1_lrd),
        .walk1_prd     (arr_walk1_prd),
        .walk0_lrd_out (walk0_lrd),
        .walk0_prd_out (walk0_prd),
        .walk1_lrd_out (walk1_lrd),
        .walk1_prd_out (walk1_prd),
        .*
    );

endmodule

`default_nettype wire

//--- verif/rob_properties.sv
`timescale 1ns/10ps
`default_nettype none
`include "rob_config.svh"

module rob_properties (
    input wire                 clock,
    input wire                 reset_n,
    input wire [1:0]           state,
    input wire                 enq_ready,
    input wire                 commit_valid,
    input wire                 commit_ready,
    input wire                 commit_fire,
    input wire [`PC_W-1:0]     commit_pc,
    input wire [`LREG_W-1:0]   commit_lrd,
    input wire [`PREG_W-1:0]   commit_prd,
    input wire [`PREG_W-1:0]   commit_old_prd,
    input wire                 commit_skip
);
    import rob_pkg::*;

    // recovery blocks new instructions
    enq_idle_a: assert property (@(posedge clock) disable iff (!reset_n)
        (state != ROB_STATE_IDLE) |-> !enq_ready)
        else $error("enq_ready high outside idle state");

    commit_idle_a: assert property (@(posedge clock) disable iff (!reset_n)
        (state != ROB_STATE_IDLE) |-> !commit_fire)
        else $error("commit outside idle state");

    // stalled head keeps its fields
    commit_hold_a: assert property (@(posedge clock) disable iff (!reset_n)
        (commit_valid && !commit_ready) |=> ($stable(commit_pc) && $stable(commit_lrd)
            && $stable(commit_prd) && $stable(commit_old_prd) && $stable(commit_skip)))
        else $error("commit fields changed while stalled");

    overwrite_once_a: assert property (@(posedge clock) disable iff (!reset_n)
        (state == ROB_STATE_OVERWRITE) |=> (state == ROB_STATE_WALKING))
        else $error("overwrite state lasted more than one cycle");

endmodule

bind rob_top rob_properties props_i (
    .clock          (clock),
    .reset_n        (reset_n),
    .state          (state),
    .enq_ready      (enq_ready),
    .commit_valid   (commit_valid),
    .commit_ready   (commit_ready),
    .commit_fire    (commit_fire),
    .commit_pc      (commit_pc),
    .commit_lrd     (commit_lrd),
    .commit_prd     (commit_prd),
    .commit_old_prd (commit_old_prd),
    .commit_skip    (commit_skip)
);

`default_nettype wire

//--- verif/rob_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rob_config.svh"

module rob_tb;

    localparam int SEED        = 63426;
    localparam int CYCLE_LIMIT = 4000;
    localparam int IDX_W       = `ROB_IDX_W;
    localparam int PTR_W       = `ROB_IDX_W + 1;
    localparam int LREG_W      = `LREG_W;
    localparam int PREG_W      = `PREG_W;

    typedef struct packed {
        logic [PTR_W-1:0]  ptr;
        logic [`PC_W-1:0]  pc;
        logic [LREG_W-1:0] lrd;
        logic [PREG_W-1:0] prd;
        logic [PREG_W-1:0] old_prd;
        logic              need_wb;
        logic              done;
        logic              skip;
    } rob_rec_t;

    logic clock;
    logic reset_n;
    logic enq0_valid, enq0_need_to_wb, enq1_valid, enq1_need_to_wb;
    logic [`PC_W-1:0]  enq0_pc, enq1_pc;
    logic [LREG_W-1:0] enq0_lrd, enq1_lrd;
    logic [PREG_W-1:0] enq0_prd, enq0_old_prd, enq1_prd, enq1_old_prd;
    logic enq_ready, enq_robidx_flag;
    logic [IDX_W-1:0]  enq_robidx;
    logic wb0_valid, wb1_valid, wb1_mmio, wb2_valid;
    logic [IDX_W-1:0]  wb0_robidx, wb1_robidx, wb2_robidx;
    logic commit_valid, commit_skip, commit_ready;
    logic [`PC_W-1:0]  commit_pc;
    logic [LREG_W-1:0] commit_lrd;
    logic [PREG_W-1:0] commit_prd, commit_old_prd;
    logic flush_valid, flush_robidx_flag;
    logic [IDX_W-1:0]  flush_robidx;
    logic walk0_valid, walk1_valid;
    logic [LREG_W-1:0] walk0_lrd, walk1_lrd;
    logic [PREG_W-1:0] walk0_prd, walk1_prd;

    // reference model state
    rob_rec_t                  model[$];
    logic [LREG_W+PREG_W-1:0]  walk_exp[$];
    logic [PTR_W-1:0]          model_enq_ptr;
    int                        rec_left;
    // pointers the stimulus has enqueued, oldest first
    logic [PTR_W-1:0]          inflight[$];

    int errors;
    int checks;
    int commits;
    int cycles;
    int test_errors;

    rob_top dut_i (.*);

    always #20 clock = ~clock;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // head may retire only when done and no recovery or flush is pending
    function automatic logic commit_expected(input logic idle, input logic flush);
        if (!idle || flush || model.size() == 0) begin
            return 1'b0;
        end
        return model[0].done;
    endfunction

    // two entries per walk cycle, the last pair ends on a hole or at the wrap
    function automatic int walk_cycles(input int n);
        if (n >= `ROB_SIZE) begin
            return `ROB_SIZE / 2;
        end
        return n / 2 + 1;
    endfunction

    function automatic void build_walk(input int n);
        walk_exp.delete();
        for (int i = 0; i < n; i++) begin
            if (model[i].need_wb) begin
                walk_exp.push_back({model[i].lrd, model[i].prd});
            end
        end
    endfunction

    function automatic int find_pos(input logic [IDX_W-1:0] idx);
        for (int i = 0; i < model.size(); i++) begin
            if (model[i].ptr[IDX_W-1:0] == idx) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic rob_rec_t make_rec(input logic [`PC_W-1:0] pc, input logic [LREG_W-1:0] lrd,
                                          input logic [PREG_W-1:0] prd,
                                          input logic [PREG_W-1:0] old_prd, input logic need);
        rob_rec_t rec;
        rec.ptr     = model_enq_ptr;
        rec.pc      = pc;
        rec.lrd     = lrd;
        rec.prd     = prd;
        rec.old_prd = old_prd;
        rec.need_wb = need;
        rec.done    = 1'b0;
        rec.skip    = 1'b0;
        return rec;
    endfunction

    task automatic mark_done(input logic [IDX_W-1:0] idx, input logic mmio);
        int pos;
        pos = find_pos(idx);
        if (pos < 0) begin
            errors++;
            $display("writeback to index %0d that is not in flight at %0d ns", idx, $time);
        end else begin
            model[pos].done = 1'b1;
            if (mmio) begin
                model[pos].skip = 1'b1;
            end
        end
    endtask

    task automatic compare_walk(input int lane, input logic [LREG_W+PREG_W-1:0] got);
        if (walk_exp.size() == 0) begin
            errors++;
            $display("walk lane %0d valid with no entry left to walk at %0d ns", lane, $time);
        end else begin
            check_value($sformatf("walk%0d lrd/prd", lane), 32'(got), 32'(walk_exp.pop_front()));
        end
    endtask

    // outputs are settled at the falling edge, inputs take effect at the next rising edge
    always @(negedge clock) begin : compare_proc
        logic idle;
        logic ready_exp;
        int pos;
        rob_rec_t rec;
        if (reset_n) begin
            idle = (rec_left == 0);
            ready_exp = idle && (`ROB_SIZE - model.size() >= 2);
            check_value("enq_ready", 32'(enq_ready), 32'(ready_exp));
            if (idle) begin
                check_value("enq_robidx", 32'({enq_robidx_flag, enq_robidx}), 32'(model_enq_ptr));
            end
            check_value("commit_valid", 32'(commit_valid),
                        32'(commit_expected(idle, flush_valid)));
            if (commit_valid && commit_ready) begin
                if (model.size() == 0) begin
                    errors++;
                    $display("commit with nothing in flight at %0d ns", $time);
                end else begin
                    rec = model.pop_front();
                    check_value("commit_pc", commit_pc, rec.pc);
                    check_value("commit_lrd", 32'(commit_lrd), 32'(rec.lrd));
                    check_value("commit_prd", 32'(commit_prd), 32'(rec.prd));
                    check_value("commit_old_prd", 32'(commit_old_prd), 32'(rec.old_prd));
                    check_value("commit_skip", 32'(commit_skip), 32'(rec.skip));
                    commits++;
                end
            end
            if (walk0_valid) begin
                compare_walk(0, {walk0_lrd, walk0_prd});
            end
            if (walk1_valid) begin
                compare_walk(1, {walk1_lrd, walk1_prd});
            end
            if (rec_left > 0) begin
                rec_left--;
            end
            if (wb0_valid) begin
                mark_done(wb0_robidx, 1'b0);
            end
            if (wb1_valid) begin
                mark_done(wb1_robidx, wb1_mmio);
            end
            if (wb2_valid) begin
                mark_done(wb2_robidx, 1'b0);
            end
            if (ready_exp && enq0_valid) begin
                model.push_back(make_rec(enq0_pc, enq0_lrd, enq0_prd, enq0_old_prd,
                                         enq0_need_to_wb));
                model_enq_ptr = model_enq_ptr + PTR_W'(1);
            end
            if (ready_exp && enq1_valid) begin
                model.push_back(make_rec(enq1_pc, enq1_lrd, enq1_prd, enq1_old_prd,
                                         enq1_need_to_wb));
                model_enq_ptr = model_enq_ptr + PTR_W'(1);
            end
            if (flush_valid && idle) begin
                pos = find_pos(flush_robidx);
                if (pos < 0) begin
                    errors++;
                    $display("flush names an entry that is not in flight at %0d ns", $time);
                end else begin
                    build_walk(pos + 1);
                    while (model.size() > pos + 1) begin
                        void'(model.pop_back());
                    end
                    model_enq_ptr = {flush_robidx_flag, flush_robidx} + PTR_W'(1);
                    rec_left = 1 + walk_cycles(pos + 1);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a test stopped making progress", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic enqueue(input bit two_lanes);
        enq0_valid      = 1'b1;
        enq0_pc         = $urandom;
        enq0_lrd        = LREG_W'($urandom);
        enq0_prd        = PREG_W'($urandom);
        enq0_old_prd    = PREG_W'($urandom);
        enq0_need_to_wb = 1'($urandom);
        enq1_valid      = two_lanes;
        enq1_pc         = $urandom;
        enq1_lrd        = LREG_W'($urandom);
        enq1_prd        = PREG_W'($urandom);
        enq1_old_prd    = PREG_W'($urandom);
        enq1_need_to_wb = 1'($urandom);
        while (!enq_ready) begin
            next_cycle();
        end
        inflight.push_back({enq_robidx_flag, enq_robidx});
        if (two_lanes) begin
            inflight.push_back({enq_robidx_flag, enq_robidx} + PTR_W'(1));
        end
        next_cycle();
        enq0_valid = 1'b0;
        enq1_valid = 1'b0;
    endtask

    // shuffled writebacks, one to three ports per cycle
    task automatic write_back_all(input bit use_mmio);
        logic [PTR_W-1:0] order[$];
        logic [PTR_W-1:0] tmp;
        int j;
        int burst;
        order = inflight;
        inflight.delete();
        for (int i = order.size() - 1; i > 0; i--) begin
            j = $urandom_range(i, 0);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        while (order.size() > 0) begin
            burst = $urandom_range(3, 1);
            tmp = order.pop_front();
            wb0_valid = 1'b1;
            wb0_robidx = tmp[IDX_W-1:0];
            if (burst > 1 && order.size() > 0) begin
                tmp = order.pop_front();
                wb1_valid = 1'b1;
                wb1_robidx = tmp[IDX_W-1:0];
                wb1_mmio = use_mmio ? 1'($urandom) : 1'b0;
            end
            if (burst > 2 && order.size() > 0) begin
                tmp = order.pop_front();
                wb2_valid = 1'b1;
                wb2_robidx = tmp[IDX_W-1:0];
            end
            next_cycle();
            wb0_valid = 1'b0;
            wb1_valid = 1'b0;
            wb1_mmio = 1'b0;
            wb2_valid = 1'b0;
        end
    endtask

    task automatic drain();
        while (model.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        logic [PTR_W-1:0] sel;
        int p;
        int base;
        void'($urandom(SEED));
        {clock, reset_n, enq0_valid, enq1_valid, commit_ready} = '0;
        {enq0_pc, enq0_lrd, enq0_prd, enq0_old_prd, enq0_need_to_wb} = '0;
        {enq1_pc, enq1_lrd, enq1_prd, enq1_old_prd, enq1_need_to_wb} = '0;
        {wb0_valid, wb0_robidx, wb1_valid, wb1_robidx, wb1_mmio, wb2_valid, wb2_robidx} = '0;
        {flush_valid, flush_robidx_flag, flush_robidx} = '0;
        {errors, checks, commits, cycles, test_errors, rec_left} = '0;
        model_enq_ptr = '0;
        repeat (5) @(posedge clock);
        #2;
        reset_n = 1'b1;
        commit_ready = 1'b1;

        repeat (6) enqueue(1'b1);
        write_back_all(1'b0);
        drain();
        finish_test("in-order commit");

        repeat (3) enqueue(1'b1);
        write_back_all(1'b1);
        drain();
        finish_test("skip marking");

        // 15 in flight leaves a single free slot
        enqueue(1'b0);
        repeat (7) enqueue(1'b1);
        repeat (3) next_cycle();
        check_value("enq_ready on full buffer", 32'(enq_ready), 32'(0));
        write_back_all(1'b0);
        drain();
        finish_test("full buffer");

        commit_ready = 1'b0;
        base = commits;
        repeat (4) enqueue(1'b1);
        write_back_all(1'b0);
        repeat (8) next_cycle();
        check_value("commit_valid while stalled", 32'(commit_valid), 32'(1));
        check_value("entries held while stalled", 32'(model.size()), 32'(8));
        if (model.size() != 0) begin
            check_value("commit_pc while stalled", commit_pc, model[0].pc);
        end
        commit_ready = 1'b1;
        drain();
        check_value("commits after release", 32'(commits - base), 32'(8));
        finish_test("commit back-pressure");

        commit_ready = 1'b0;
        repeat (5) enqueue(1'b1);
        p = $urandom_range(8, 1);
        sel = inflight[p];
        wb0_valid = 1'b1;
        wb0_robidx = inflight[0][IDX_W-1:0];
        next_cycle();
        wb0_valid = 1'b0;
        flush_valid = 1'b1;
        flush_robidx_flag = sel[IDX_W];
        flush_robidx = sel[IDX_W-1:0];
        next_cycle();
        flush_valid = 1'b0;
        while (!enq_ready) begin
            next_cycle();
        end
        check_value("walk entries not seen", 32'(walk_exp.size()), 32'(0));
        check_value("enq_robidx after flush", 32'({enq_robidx_flag, enq_robidx}),
                    32'(sel + PTR_W'(1)));
        finish_test("flush and walk");

        // only the head and the survivors up to the flush entry remain
        base = commits;
        while (inflight.size() > p + 1) begin
            void'(inflight.pop_back());
        end
        void'(inflight.pop_front());
        commit_ready = 1'b1;
        write_back_all(1'b0);
        drain();
        check_value("survivor commits", 32'(commits - base), 32'(p + 1));
        enqueue(1'b1);
        write_back_all(1'b0);
        drain();
        check_value("commits after refill", 32'(commits - base), 32'(p + 3));
        finish_test("surviving entries after flush");

        $display("%0d checks, %0d errors, %0d commits", checks, errors, commits);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rob_core.f
+incdir+common
common/rob_pkg.sv
rob/rob_entry_array.sv
rob/rob_pointers.sv
rob/rob_recovery.sv
verilog/rob_top.sv
verif/rob_properties.sv
verif/rob_tb.sv

//--- Makefile
TOP := rob_tb
LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f rob_core.f -o V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rob_core.f

clean:
	rm -rf obj_dir $(LOG)
